//--- project.f
+incdir+include
hdl/i3c_target_pkg.sv
hdl/i3c_bus_decode.sv
hdl/i3c_xfer_execute.sv
hdl/i3c_result_regs.sv
hdl/i3c_standby_top.sv
verif/i3c_standby_assert.sv
verif/tb_i3c_standby.sv

//--- verif/tb_i3c_standby.sv
// Bus levels held 6 clocks per step; RX queue full changes only between bytes, reset done only between frames
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module tb_i3c_standby;

  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 16;
  localparam int Hold = 6;
  localparam int NumFrames = 60;
  // Up to two parts of five bytes, three steps per bit, plus conditions and checks
  localparam int MaxFrameCycles = 2 * (5 * 9 * 3 * Hold + 4 * Hold) + 100;
  localparam int WatchdogNs = (NumFrames * MaxFrameCycles + ResetCycles) * ClkPeriod * 2;
  localparam logic [6:0] OwnAddr = 7'h35;
  localparam logic [6:0] StaAddr = 7'h1C;
  localparam logic [5:0] CondStart = 6'd1;
  localparam logic [5:0] CondRstart = 6'd2;
  localparam logic [5:0] CondStop = 6'd3;

  logic clk_i;
  logic rst_ni;
  logic i3c_standby_en_i;
  logic ctrl_scl_i;
  logic ctrl_sda_i;
  logic target_dyn_addr_valid_i;
  logic rx_queue_full_i;
  logic peripheral_reset_done_i;
  logic bus_start_o;
  logic bus_rstart_o;
  logic bus_stop_o;
  i3c_target_pkg::i3c_byte_t bus_addr_o;
  logic bus_addr_valid_o;
  logic rx_queue_wvalid_o;
  i3c_target_pkg::i3c_byte_t rx_queue_wdata_o;
  logic enec_ibi_o;
  logic enec_crr_o;
  logic enec_hj_o;
  logic disec_ibi_o;
  logic disec_crr_o;
  logic disec_hj_o;
  logic set_mwl_o;
  logic [`I3C_MWL_W-1:0] mwl_o;
  i3c_target_pkg::rst_action_e rst_action_o;
  logic rst_action_valid_o;
  logic peripheral_reset_o;
  logic escalated_reset_o;

  integer seed = 32'h37fb;
  logic periph_exp;
  logic esc_exp;

  // Expected results from the frames sent, and what the DUT produced
  logic [5:0] exp_cond[$];
  logic [5:0] got_cond[$];
  i3c_target_pkg::i3c_byte_t exp_addr[$];
  i3c_target_pkg::i3c_byte_t got_addr[$];
  i3c_target_pkg::i3c_byte_t exp_rx[$];
  i3c_target_pkg::i3c_byte_t got_rx[$];
  logic [5:0] exp_evt[$];
  logic [5:0] got_evt[$];
  logic [`I3C_MWL_W-1:0] exp_mwl[$];
  logic [`I3C_MWL_W-1:0] got_mwl[$];
  i3c_target_pkg::rst_action_e exp_act[$];
  i3c_target_pkg::rst_action_e got_act[$];

  i3c_standby_top u_i3c_standby_top (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .i3c_standby_en_i        (i3c_standby_en_i),
    .ctrl_scl_i              (ctrl_scl_i),
    .ctrl_sda_i              (ctrl_sda_i),
    .target_sta_addr_i       (StaAddr),
    .target_sta_addr_valid_i (1'b1),
    .target_dyn_addr_i       (OwnAddr),
    .target_dyn_addr_valid_i (target_dyn_addr_valid_i),
    .rx_queue_full_i         (rx_queue_full_i),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .bus_start_o             (bus_start_o),
    .bus_rstart_o            (bus_rstart_o),
    .bus_stop_o              (bus_stop_o),
    .bus_addr_o              (bus_addr_o),
    .bus_addr_valid_o        (bus_addr_valid_o),
    .rx_queue_wvalid_o       (rx_queue_wvalid_o),
    .rx_queue_wdata_o        (rx_queue_wdata_o),
    .enec_ibi_o              (enec_ibi_o),
    .enec_crr_o              (enec_crr_o),
    .enec_hj_o               (enec_hj_o),
    .disec_ibi_o             (disec_ibi_o),
    .disec_crr_o             (disec_crr_o),
    .disec_hj_o              (disec_hj_o),
    .set_mwl_o               (set_mwl_o),
    .mwl_o                   (mwl_o),
    .rst_action_o            (rst_action_o),
    .rst_action_valid_o      (rst_action_valid_o),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout: the run did not finish within %0d ns", WatchdogNs);
    abort_run();
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Dynamic address wins while it is valid
  function automatic logic [6:0] own_addr();
    return target_dyn_addr_valid_i ? OwnAddr : StaAddr;
  endfunction

  task automatic check_byte(input string what, input i3c_target_pkg::i3c_byte_t got,
                            input i3c_target_pkg::i3c_byte_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_action(input i3c_target_pkg::rst_action_e got,
                              input i3c_target_pkg::rst_action_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: reset action got %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mwl(input string what, input logic [`I3C_MWL_W-1:0] got,
                           input logic [`I3C_MWL_W-1:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flags(input string what, input logic [5:0] got, input logic [5:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t ns: %0d %s seen, expected %0d", $time, got, what, exp);
      abort_run();
    end
  endtask

  task automatic check_levels();
    check_flags("reset levels", {4'b0, peripheral_reset_o, escalated_reset_o},
                {4'b0, periph_exp, esc_exp});
  endtask

  // Monitor samples on the falling edge between DUT updates
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1) begin
      if (bus_start_o) got_cond.push_back(CondStart);
      if (bus_rstart_o) got_cond.push_back(CondRstart);
      if (bus_stop_o) got_cond.push_back(CondStop);
      if (bus_addr_valid_o) got_addr.push_back(bus_addr_o);
      if (rx_queue_wvalid_o) got_rx.push_back(rx_queue_wdata_o);
      if (set_mwl_o) got_mwl.push_back(mwl_o);
      if (rst_action_valid_o) got_act.push_back(rst_action_o);
      if (|{enec_ibi_o, enec_crr_o, enec_hj_o, disec_ibi_o, disec_crr_o, disec_hj_o}) begin
        got_evt.push_back({enec_ibi_o, enec_crr_o, enec_hj_o,
                           disec_ibi_o, disec_crr_o, disec_hj_o});
      end
    end
  end

  task automatic bus_step(input logic scl, input logic sda);
    @(posedge clk_i);
    ctrl_scl_i <= scl;
    ctrl_sda_i <= sda;
    repeat (Hold - 1) @(posedge clk_i);
  endtask

  // SCL falls first, SDA changes while low, then SCL rises
  task automatic send_bit(input logic b);
    bus_step(1'b0, ctrl_sda_i);
    bus_step(1'b0, b);
    bus_step(1'b1, b);
  endtask

  task automatic send_byte(input i3c_target_pkg::i3c_byte_t b, input logic to_rx);
    logic full;
    full = (rand_below(4) == 0);
    @(posedge clk_i);
    rx_queue_full_i <= full;
    if (to_rx && !full) exp_rx.push_back(b);
    for (int i = `I3C_DATA_W - 1; i >= 0; i--) send_bit(b[i]);
    send_bit(1'b1);
  endtask

  task automatic send_addr(input i3c_target_pkg::i3c_byte_t b);
    exp_addr.push_back(b);
    send_byte(b, 1'b0);
  endtask

  task automatic send_part(input int kind);
    i3c_target_pkg::i3c_byte_t b1;
    i3c_target_pkg::i3c_byte_t b2;
    logic [6:0] addr;
    int n;
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    addr = 7'($random(seed));
    n = 1 + rand_below(4);
    case (kind)
      0: begin
        send_addr({own_addr(), 1'b0});
        for (int i = 0; i < n; i++) begin
          b1 = 8'($random(seed));
          send_byte(b1, 1'b1);
        end
      end
      1: begin
        // Sometimes the address that is not in use
        if (rand_below(2) == 0) addr = target_dyn_addr_valid_i ? StaAddr : OwnAddr;
        if (addr == own_addr() || addr == `I3C_BCAST_ADDR) addr = addr ^ 7'h01;
        send_addr({addr, 1'b0});
        send_byte(b1, 1'b0);
      end
      2: begin
        send_addr({addr, 1'b1});
        send_byte(b1, 1'b0);
      end
      3, 4: begin
        send_addr({`I3C_BCAST_ADDR, 1'b0});
        send_byte((kind == 3) ? `I3C_CCC_ENEC : `I3C_CCC_DISEC, 1'b0);
        send_byte(b1, 1'b0);
        if (b1[0] | b1[1] | b1[3]) begin
          if (kind == 3) exp_evt.push_back({b1[0], b1[1], b1[3], 3'b000});
          else exp_evt.push_back({3'b000, b1[0], b1[1], b1[3]});
        end
      end
      5: begin
        send_addr({`I3C_BCAST_ADDR, 1'b0});
        send_byte(`I3C_CCC_SETMWL, 1'b0);
        send_byte(b1, 1'b0);
        send_byte(b2, 1'b0);
        exp_mwl.push_back({b1, b2});
      end
      6: begin
        b1 = 8'(1 + rand_below(2));
        send_addr({`I3C_BCAST_ADDR, 1'b0});
        send_byte(`I3C_CCC_RSTACT, 1'b0);
        send_byte(b1, 1'b0);
        exp_act.push_back(i3c_target_pkg::rst_action_e'(b1));
        if (b1 == `I3C_RSTACT_PERIPH) periph_exp = 1'b1;
        else esc_exp = 1'b1;
      end
      default: begin
        if (b2 == 8'h00 || b2 == 8'h01 || b2 == 8'h09 || b2 == 8'h2A) b2 = b2 + 8'h10;
        send_addr({`I3C_BCAST_ADDR, 1'b0});
        send_byte(b2, 1'b0);
        send_byte(b1, 1'b0);
      end
    endcase
  endtask

  task automatic send_frame();
    int parts;
    parts = (rand_below(4) == 0) ? 2 : 1;
    bus_step(1'b1, 1'b1);
    bus_step(1'b1, 1'b0);
    exp_cond.push_back(CondStart);
    for (int p = 0; p < parts; p++) begin
      if (p > 0) begin
        bus_step(1'b0, ctrl_sda_i);
        bus_step(1'b0, 1'b1);
        bus_step(1'b1, 1'b1);
        bus_step(1'b1, 1'b0);
        exp_cond.push_back(CondRstart);
      end
      send_part(rand_below(8));
    end
    bus_step(1'b0, ctrl_sda_i);
    bus_step(1'b0, 1'b0);
    bus_step(1'b1, 1'b0);
    bus_step(1'b1, 1'b1);
    exp_cond.push_back(CondStop);
  endtask

  task automatic check_frame();
    repeat (4) @(posedge clk_i);
    check_count("bus conditions", got_cond.size(), exp_cond.size());
    foreach (exp_cond[i]) check_flags("bus condition", got_cond[i], exp_cond[i]);
    check_count("addresses", got_addr.size(), exp_addr.size());
    foreach (exp_addr[i]) check_byte("address", got_addr[i], exp_addr[i]);
    check_count("RX writes", got_rx.size(), exp_rx.size());
    foreach (exp_rx[i]) check_byte("RX data", got_rx[i], exp_rx[i]);
    check_count("event pulses", got_evt.size(), exp_evt.size());
    foreach (exp_evt[i]) check_flags("event pulses", got_evt[i], exp_evt[i]);
    check_count("SETMWL pulses", got_mwl.size(), exp_mwl.size());
    foreach (exp_mwl[i]) check_mwl("max write length", got_mwl[i], exp_mwl[i]);
    check_count("reset actions", got_act.size(), exp_act.size());
    foreach (exp_act[i]) check_action(got_act[i], exp_act[i]);
    check_levels();
    exp_cond.delete();
    got_cond.delete();
    exp_addr.delete();
    got_addr.delete();
    exp_rx.delete();
    got_rx.delete();
    exp_evt.delete();
    got_evt.delete();
    exp_mwl.delete();
    got_mwl.delete();
    exp_act.delete();
    got_act.delete();
  endtask

  initial begin
    rst_ni = 1'b0;
    i3c_standby_en_i = 1'b1;
    ctrl_scl_i = 1'b1;
    ctrl_sda_i = 1'b1;
    target_dyn_addr_valid_i = 1'b1;
    rx_queue_full_i = 1'b0;
    peripheral_reset_done_i = 1'b0;
    periph_exp = 1'b0;
    esc_exp = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    check_levels();
    check_mwl("max write length after reset", mwl_o, '0);
    for (int f = 0; f < NumFrames; f++) begin
      // Static address in use now and then
      @(posedge clk_i);
      target_dyn_addr_valid_i <= (rand_below(4) != 0);
      send_frame();
      check_frame();
      // Reset done pulses only between frames
      if (rand_below(3) == 0) begin
        @(posedge clk_i);
        peripheral_reset_done_i <= 1'b1;
        @(posedge clk_i);
        peripheral_reset_done_i <= 1'b0;
        periph_exp = 1'b0;
        repeat (2) @(posedge clk_i);
        check_levels();
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/i3c_standby_assert.sv
// Observes only top level ports through bind; checks are disabled while rst_ni is low
`timescale 1ns/1ps
`default_nettype none

module i3c_standby_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic bus_start_i,
  input logic bus_rstart_i,
  input logic bus_stop_i,
  input logic rx_queue_full_i,
  input logic rx_queue_wvalid_i,
  input logic escalated_reset_i
);

  // A START and a STOP need opposite SDA edges
  a_start_stop_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_start_i || bus_rstart_i) && bus_stop_i))
    else $error("START and STOP pulsed in the same cycle");

  // Queue full in the strobe cycle drops the write
  a_full_drops_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_full_i |=> !rx_queue_wvalid_i)
    else $error("RX queue written while it was full");

  a_escalate_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalated_reset_i |=> escalated_reset_i)
    else $error("escalated reset fell without a reset");

endmodule

bind i3c_standby_top i3c_standby_assert u_standby_assert (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .bus_start_i       (bus_start_o),
  .bus_rstart_i      (bus_rstart_o),
  .bus_stop_i        (bus_stop_o),
  .rx_queue_full_i   (rx_queue_full_i),
  .rx_queue_wvalid_i (rx_queue_wvalid_o),
  .escalated_reset_i (escalated_reset_o)
);

`default_nettype wire

//--- hdl/i3c_standby_top.sv
// Receive-only I3C target front end; no SDA drive, so the controller sees no ACK from this block
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_standby_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        i3c_standby_en_i,
  input  logic                        ctrl_scl_i,
  input  logic                        ctrl_sda_i,
  input  i3c_target_pkg::i3c_addr_t   target_sta_addr_i,
  input  logic                        target_sta_addr_valid_i,
  input  i3c_target_pkg::i3c_addr_t   target_dyn_addr_i,
  input  logic                        target_dyn_addr_valid_i,
  input  logic                        rx_queue_full_i,
  input  logic                        peripheral_reset_done_i,
  output logic                        bus_start_o,
  output logic                        bus_rstart_o,
  output logic                        bus_stop_o,
  output i3c_target_pkg::i3c_byte_t   bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        rx_queue_wvalid_o,
  output i3c_target_pkg::i3c_byte_t   rx_queue_wdata_o,
  output logic                        enec_ibi_o,
  output logic                        enec_crr_o,
  output logic                        enec_hj_o,
  output logic                        disec_ibi_o,
  output logic                        disec_crr_o,
  output logic                        disec_hj_o,
  output logic                        set_mwl_o,
  output logic [`I3C_MWL_W-1:0]       mwl_o,
  output i3c_target_pkg::rst_action_e rst_action_o,
  output logic                        rst_action_valid_o,
  output logic                        peripheral_reset_o,
  output logic                        escalated_reset_o
);

  logic byte_valid;
  i3c_target_pkg::i3c_byte_t byte_data;
  logic rx_byte_valid;
  i3c_target_pkg::i3c_byte_t rx_byte;

  i3c_bus_decode u_bus_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (i3c_standby_en_i),
    .scl_i        (ctrl_scl_i),
    .sda_i        (ctrl_sda_i),
    .start_o      (bus_start_o),
    .rstart_o     (bus_rstart_o),
    .stop_o       (bus_stop_o),
    .byte_valid_o (byte_valid),
    .byte_o       (byte_data)
  );

  i3c_xfer_execute u_xfer_execute (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .start_i            (bus_start_o),
    .rstart_i           (bus_rstart_o),
    .stop_i             (bus_stop_o),
    .byte_valid_i       (byte_valid),
    .byte_i             (byte_data),
    .sta_addr_i         (target_sta_addr_i),
    .dyn_addr_i         (target_dyn_addr_i),
    .sta_addr_valid_i   (target_sta_addr_valid_i),
    .dyn_addr_valid_i   (target_dyn_addr_valid_i),
    .bus_addr_o         (bus_addr_o),
    .bus_addr_valid_o   (bus_addr_valid_o),
    .rx_byte_valid_o    (rx_byte_valid),
    .rx_byte_o          (rx_byte),
    .enec_ibi_o         (enec_ibi_o),
    .enec_crr_o         (enec_crr_o),
    .enec_hj_o          (enec_hj_o),
    .disec_ibi_o        (disec_ibi_o),
    .disec_crr_o        (disec_crr_o),
    .disec_hj_o         (disec_hj_o),
    .set_mwl_o          (set_mwl_o),
    .mwl_o              (mwl_o),
    .rst_action_o       (rst_action_o),
    .rst_action_valid_o (rst_action_valid_o)
  );

  i3c_result_regs u_result_regs (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .rx_byte_valid_i         (rx_byte_valid),
    .rx_byte_i               (rx_byte),
    .rx_queue_full_i         (rx_queue_full_i),
    .rst_action_i            (rst_action_o),
    .rst_action_valid_i      (rst_action_valid_o),
    .peripheral_reset_done_i (peripheral_reset_done_i),
    .rx_queue_wvalid_o       (rx_queue_wvalid_o),
    .rx_queue_wdata_o        (rx_queue_wdata_o),
    .peripheral_reset_o      (peripheral_reset_o),
    .escalated_reset_o       (escalated_reset_o)
  );

endmodule

`default_nettype wire

//--- hdl/i3c_result_regs.sv
// RX bytes arriving while the queue is full are dropped; escalated reset clears only on rst_ni
`timescale 1ns/1ps
`default_nettype none

module i3c_result_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rx_byte_valid_i,
  input  i3c_target_pkg::i3c_byte_t   rx_byte_i,
  input  logic                        rx_queue_full_i,
  input  i3c_target_pkg::rst_action_e rst_action_i,
  input  logic                        rst_action_valid_i,
  input  logic                        peripheral_reset_done_i,
  output logic                        rx_queue_wvalid_o,
  output i3c_target_pkg::i3c_byte_t   rx_queue_wdata_o,
  output logic                        peripheral_reset_o,
  output logic                        escalated_reset_o
);

  logic periph_req;
  logic escalate_req;

  assign periph_req   = rst_action_valid_i & (rst_action_i == i3c_target_pkg::RstPeripheral);
  assign escalate_req = rst_action_valid_i & (rst_action_i == i3c_target_pkg::RstEscalate);

  // Full is sampled with the byte strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_queue_wvalid_o <= 1'b0;
      rx_queue_wdata_o  <= '0;
    end else begin
      rx_queue_wvalid_o <= rx_byte_valid_i & ~rx_queue_full_i;
      if (rx_byte_valid_i) begin
        rx_queue_wdata_o <= rx_byte_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
    end else begin
      if (periph_req) begin
        peripheral_reset_o <= 1'b1;
      end
      // Done wins over a new request
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalated_reset_o <= 1'b0;
    end else if (escalate_req) begin
      escalated_reset_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/i3c_xfer_execute.sv
// Write-only target; reads and unknown CCCs are skipped until the next START, Sr or STOP
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_xfer_execute (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic                        rstart_i,
  input  logic                        stop_i,
  input  logic                        byte_valid_i,
  input  i3c_target_pkg::i3c_byte_t   byte_i,
  input  i3c_target_pkg::i3c_addr_t   sta_addr_i,
  input  i3c_target_pkg::i3c_addr_t   dyn_addr_i,
  input  logic                        sta_addr_valid_i,
  input  logic                        dyn_addr_valid_i,
  output i3c_target_pkg::i3c_byte_t   bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        rx_byte_valid_o,
  output i3c_target_pkg::i3c_byte_t   rx_byte_o,
  output logic                        enec_ibi_o,
  output logic                        enec_crr_o,
  output logic                        enec_hj_o,
  output logic                        disec_ibi_o,
  output logic                        disec_crr_o,
  output logic                        disec_hj_o,
  output logic                        set_mwl_o,
  output logic [`I3C_MWL_W-1:0]       mwl_o,
  output i3c_target_pkg::rst_action_e rst_action_o,
  output logic                        rst_action_valid_o
);

  i3c_target_pkg::xfer_state_e state_q;
  i3c_target_pkg::ccc_op_e ccc_q;
  logic mwl_idx_q;
  i3c_target_pkg::i3c_byte_t mwl_msb_q;

  i3c_target_pkg::i3c_addr_t own_addr;
  logic own_valid;
  i3c_target_pkg::i3c_addr_t rx_addr;
  logic rx_rnw;
  logic addr_hit;
  logic bcast_hit;
  logic ccc_known;

  // Dynamic address takes over once assigned
  assign own_valid = dyn_addr_valid_i | sta_addr_valid_i;
  assign own_addr  = dyn_addr_valid_i ? dyn_addr_i : sta_addr_i;

  assign rx_addr   = byte_i[`I3C_DATA_W-1:1];
  assign rx_rnw    = byte_i[0];
  assign addr_hit  = own_valid & (rx_addr == own_addr) & ~rx_rnw;
  assign bcast_hit = (rx_addr == `I3C_BCAST_ADDR) & ~rx_rnw;

  always_comb begin
    case (byte_i)
      i3c_target_pkg::CccEnec,
      i3c_target_pkg::CccDisec,
      i3c_target_pkg::CccSetmwl,
      i3c_target_pkg::CccRstact: ccc_known = 1'b1;
      default: ccc_known = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= i3c_target_pkg::StIdle;
      ccc_q              <= i3c_target_pkg::CccEnec;
      mwl_idx_q          <= 1'b0;
      bus_addr_o         <= '0;
      bus_addr_valid_o   <= 1'b0;
      rx_byte_valid_o    <= 1'b0;
      enec_ibi_o         <= 1'b0;
      enec_crr_o         <= 1'b0;
      enec_hj_o          <= 1'b0;
      disec_ibi_o        <= 1'b0;
      disec_crr_o        <= 1'b0;
      disec_hj_o         <= 1'b0;
      set_mwl_o          <= 1'b0;
      mwl_o              <= '0;
      rst_action_o       <= i3c_target_pkg::RstNone;
      rst_action_valid_o <= 1'b0;
    end else begin
      bus_addr_valid_o   <= 1'b0;
      rx_byte_valid_o    <= 1'b0;
      enec_ibi_o         <= 1'b0;
      enec_crr_o         <= 1'b0;
      enec_hj_o          <= 1'b0;
      disec_ibi_o        <= 1'b0;
      disec_crr_o        <= 1'b0;
      disec_hj_o         <= 1'b0;
      set_mwl_o          <= 1'b0;
      rst_action_valid_o <= 1'b0;

      if (stop_i) begin
        state_q <= i3c_target_pkg::StIdle;
      end else if (start_i || rstart_i) begin
        state_q   <= i3c_target_pkg::StAddr;
        mwl_idx_q <= 1'b0;
      end else if (byte_valid_i) begin
        case (state_q)
          i3c_target_pkg::StAddr: begin
            bus_addr_o       <= byte_i;
            bus_addr_valid_o <= 1'b1;
            if (bcast_hit) begin
              state_q <= i3c_target_pkg::StCccCode;
            end else if (addr_hit) begin
              state_q <= i3c_target_pkg::StPrivWrite;
            end else begin
              state_q <= i3c_target_pkg::StIgnore;
            end
          end
          i3c_target_pkg::StPrivWrite: begin
            rx_byte_valid_o <= 1'b1;
          end
          i3c_target_pkg::StCccCode: begin
            ccc_q     <= i3c_target_pkg::ccc_op_e'(byte_i);
            mwl_idx_q <= 1'b0;
            state_q   <= ccc_known ? i3c_target_pkg::StCccDefByte : i3c_target_pkg::StIgnore;
          end
          i3c_target_pkg::StCccDefByte: begin
            case (ccc_q)
              i3c_target_pkg::CccEnec: begin
                enec_ibi_o <= byte_i[`I3C_EVT_IBI_BIT];
                enec_crr_o <= byte_i[`I3C_EVT_CRR_BIT];
                enec_hj_o  <= byte_i[`I3C_EVT_HJ_BIT];
                state_q    <= i3c_target_pkg::StIgnore;
              end
              i3c_target_pkg::CccDisec: begin
                disec_ibi_o <= byte_i[`I3C_EVT_IBI_BIT];
                disec_crr_o <= byte_i[`I3C_EVT_CRR_BIT];
                disec_hj_o  <= byte_i[`I3C_EVT_HJ_BIT];
                state_q     <= i3c_target_pkg::StIgnore;
              end
              // MWL arrives MSB first over two bytes
              i3c_target_pkg::CccSetmwl: begin
                if (!mwl_idx_q) begin
                  mwl_idx_q <= 1'b1;
                end else begin
                  mwl_o     <= {mwl_msb_q, byte_i};
                  set_mwl_o <= 1'b1;
                  mwl_idx_q <= 1'b0;
                  state_q   <= i3c_target_pkg::StIgnore;
                end
              end
              i3c_target_pkg::CccRstact: begin
                rst_action_o       <= i3c_target_pkg::rst_action_e'(byte_i);
                rst_action_valid_o <= 1'b1;
                state_q            <= i3c_target_pkg::StIgnore;
              end
              default: begin
                state_q <= i3c_target_pkg::StIgnore;
              end
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_valid_i && state_q == i3c_target_pkg::StPrivWrite) begin
      rx_byte_o <= byte_i;
    end
    if (byte_valid_i && state_q == i3c_target_pkg::StCccDefByte && !mwl_idx_q) begin
      mwl_msb_q <= byte_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/i3c_bus_decode.sv
// SCL/SDA must be held several clocks per level; bus conditions and bytes are single-cycle pulses
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_bus_decode (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output logic                     start_o,
  output logic                     rstart_o,
  output logic                     stop_o,
  output logic                     byte_valid_o,
  output i3c_target_pkg::i3c_byte_t byte_o
);

  localparam int unsigned SyncStages = `I3C_SYNC_STAGES;
  localparam logic [3:0] LastBit = 4'(`I3C_DATA_W - 1);
  localparam logic [3:0] AckBit = 4'(`I3C_DATA_W);

  logic [SyncStages-1:0] scl_sync;
  logic [SyncStages-1:0] sda_sync;
  logic scl_s;
  logic sda_s;
  logic scl_q;
  logic sda_q;

  logic scl_rise;
  logic scl_high;
  logic sda_fall;
  logic sda_rise;
  logic start_cond;
  logic stop_cond;

  logic xfer_open_q;
  logic [3:0] bit_cnt_q;
  i3c_target_pkg::i3c_byte_t shift_q;

  // Lines idle high, so the synchronizer resets to 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[SyncStages-2:0], scl_i};
      sda_sync <= {sda_sync[SyncStages-2:0], sda_i};
      scl_q    <= scl_s;
      sda_q    <= sda_s;
    end
  end

  assign scl_s = scl_sync[SyncStages-1];
  assign sda_s = sda_sync[SyncStages-1];

  assign scl_rise = scl_s & ~scl_q;
  assign scl_high = scl_s & scl_q;
  assign sda_fall = ~sda_s & sda_q;
  assign sda_rise = sda_s & ~sda_q;

  assign start_cond = enable_i & scl_high & sda_fall;
  assign stop_cond  = enable_i & scl_high & sda_rise;

  // Sr only while a transaction is open
  assign start_o  = start_cond & ~xfer_open_q;
  assign rstart_o = start_cond & xfer_open_q;
  assign stop_o   = stop_cond;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_open_q <= 1'b0;
    end else if (!enable_i || stop_cond) begin
      xfer_open_q <= 1'b0;
    end else if (start_cond) begin
      xfer_open_q <= 1'b1;
    end
  end

  // Counts 0..8, where 8 is the ACK or T-bit slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
    end else if (!enable_i || start_cond || stop_cond) begin
      bit_cnt_q <= '0;
    end else if (scl_rise) begin
      if (bit_cnt_q == AckBit) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (scl_rise && bit_cnt_q != AckBit) begin
      shift_q <= {shift_q[`I3C_DATA_W-2:0], sda_s};
    end
  end

  // Byte is complete on the rise that samples its last bit
  assign byte_valid_o = enable_i & scl_rise & (bit_cnt_q == LastBit);
  assign byte_o       = {shift_q[`I3C_DATA_W-2:0], sda_s};

endmodule

`default_nettype wire

//--- hdl/i3c_target_pkg.sv
// Types for the receive-only target; byte and address widths come from the settings header
`default_nettype none

`include "i3c_target_settings.svh"

package i3c_target_pkg;

  typedef logic [`I3C_DATA_W-1:0] i3c_byte_t;
  typedef logic [`I3C_ADDR_W-1:0] i3c_addr_t;

  // Broadcast CCCs that the target executes
  typedef enum logic [7:0] {
    CccEnec   = `I3C_CCC_ENEC,
    CccDisec  = `I3C_CCC_DISEC,
    CccSetmwl = `I3C_CCC_SETMWL,
    CccRstact = `I3C_CCC_RSTACT
  } ccc_op_e;

  typedef enum logic [2:0] {
    StIdle,
    StAddr,
    StPrivWrite,
    StCccCode,
    StCccDefByte,
    StIgnore
  } xfer_state_e;

  // Other RSTACT values are passed through as raw bytes
  typedef enum logic [7:0] {
    RstNone       = `I3C_RSTACT_NONE,
    RstPeripheral = `I3C_RSTACT_PERIPH,
    RstEscalate   = `I3C_RSTACT_ESCALATE
  } rst_action_e;

endpackage

`default_nettype wire

//--- include/i3c_target_settings.svh
// Assumes an 8-bit bus byte with a 7-bit address plus RnW bit; only the listed CCC codes exist
`ifndef I3C_TARGET_SETTINGS_SVH
`define I3C_TARGET_SETTINGS_SVH

// Data path and address widths
`define I3C_DATA_W 8
`define I3C_ADDR_W 7

// Broadcast address used for CCC frames
`define I3C_BCAST_ADDR 7'h7E

// Flops in front of the SCL and SDA edge logic
`define I3C_SYNC_STAGES 2

// Max write length as carried by SETMWL
`define I3C_MWL_W 16

// Broadcast CCC codes
`define I3C_CCC_ENEC 8'h00
`define I3C_CCC_DISEC 8'h01
`define I3C_CCC_SETMWL 8'h09
`define I3C_CCC_RSTACT 8'h2A

// RSTACT defining byte values
`define I3C_RSTACT_NONE 8'h00
`define I3C_RSTACT_PERIPH 8'h01
`define I3C_RSTACT_ESCALATE 8'h02

// Event bits in the ENEC and DISEC defining byte
`define I3C_EVT_IBI_BIT 0
`define I3C_EVT_CRR_BIT 1
`define I3C_EVT_HJ_BIT 3

`endif
